/* verilog/jtag_pkg.sv */
package jtag_pkg;

    // tap controller states, encoding follows the usual 0..15 numbering
    typedef enum logic [3:0]
    {
        test_logic_reset = 4'd0,
        run_test_idle    = 4'd1,
        select_dr_scan   = 4'd2,
        capture_dr       = 4'd3,
        shift_dr         = 4'd4,
        exit1_dr         = 4'd5,
        pause_dr         = 4'd6,
        exit2_dr         = 4'd7,
        update_dr        = 4'd8,
        select_ir_scan   = 4'd9,
        capture_ir       = 4'd10,
        shift_ir         = 4'd11,
        exit1_ir         = 4'd12,
        pause_ir         = 4'd13,
        exit2_ir         = 4'd14,
        update_ir        = 4'd15
    } tap_state_t;

    // riscv debug spec asks for at least 5 ir bits
    localparam int IR_WIDTH = 5;

    typedef logic [IR_WIDTH-1:0] ir_t;

    localparam ir_t INSTR_IDCODE = 5'h01;
    localparam ir_t INSTR_BYPASS = 5'h1f;
    localparam ir_t INSTR_CUSTOM = 5'h0a;

    typedef logic [31:0] dr32_t;

    localparam dr32_t IDCODE_VALUE = 32'h12345678;
    localparam dr32_t CUSTOM_INIT  = 32'h0a0b0c0d;

    // five rising edges with tms high reach reset from any state
    localparam int TLR_TMS_COUNT = 5;

    // pin synchronizer depth
    localparam int SYNC_STAGES = 2;

endpackage

/* verilog/jtag_sync.sv */
`timescale 1ns/1ps

module jtag_sync
(
    input  logic clk,
    input  logic rst_n,
    input  logic jtag_clk,
    input  logic jtag_tms,
    input  logic jtag_tdi,
    output logic tck_rise,
    output logic tck_fall,
    output logic tms,
    output logic tdi
);

    localparam int N = jtag_pkg::SYNC_STAGES;

    logic [N-1:0] clk_sync;
    logic [N-1:0] tms_sync;
    logic [N-1:0] tdi_sync;
    logic         clk_prev;

    // shift each pin in at bit 0, the last bit is the stable level
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            clk_sync <= '0;
            tms_sync <= '0;
            tdi_sync <= '0;
        end
        else
        begin
            clk_sync <= {clk_sync[N-2:0], jtag_clk};
            tms_sync <= {tms_sync[N-2:0], jtag_tms};
            tdi_sync <= {tdi_sync[N-2:0], jtag_tdi};
        end
    end

    // edge register, tms and tdi go through the same stage
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            clk_prev <= 1'b0;
            tck_rise <= 1'b0;
            tck_fall <= 1'b0;
            tms      <= 1'b0;
            tdi      <= 1'b0;
        end
        else
        begin
            clk_prev <= clk_sync[N-1];
            tck_rise <= clk_sync[N-1] & ~clk_prev;
            tck_fall <= ~clk_sync[N-1] & clk_prev;
            tms      <= tms_sync[N-1];
            tdi      <= tdi_sync[N-1];
        end
    end

endmodule

/* verilog/tap_fsm.sv */
`timescale 1ns/1ps

module tap_fsm
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tck_rise,
    input  logic                   tms,
    output jtag_pkg::tap_state_t   state,
    output logic                   tap_reset,
    output logic                   ir_capture,
    output logic                   ir_shift,
    output logic                   ir_update,
    output logic                   dr_capture,
    output logic                   dr_shift,
    output logic                   dr_update
);

    jtag_pkg::tap_state_t next_state;

    // standard tms transitions
    always_comb
    begin
        case (state)
            jtag_pkg::test_logic_reset:
                next_state = tms ? jtag_pkg::test_logic_reset : jtag_pkg::run_test_idle;
            jtag_pkg::run_test_idle:
                next_state = tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
            jtag_pkg::select_dr_scan:
                next_state = tms ? jtag_pkg::select_ir_scan : jtag_pkg::capture_dr;
            jtag_pkg::capture_dr:
                next_state = tms ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
            jtag_pkg::shift_dr:
                next_state = tms ? jtag_pkg::exit1_dr : jtag_pkg::shift_dr;
            jtag_pkg::exit1_dr:
                next_state = tms ? jtag_pkg::update_dr : jtag_pkg::pause_dr;
            jtag_pkg::pause_dr:
                next_state = tms ? jtag_pkg::exit2_dr : jtag_pkg::pause_dr;
            jtag_pkg::exit2_dr:
                next_state = tms ? jtag_pkg::update_dr : jtag_pkg::shift_dr;
            jtag_pkg::update_dr:
                next_state = tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
            jtag_pkg::select_ir_scan:
                next_state = tms ? jtag_pkg::test_logic_reset : jtag_pkg::capture_ir;
            jtag_pkg::capture_ir:
                next_state = tms ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
            jtag_pkg::shift_ir:
                next_state = tms ? jtag_pkg::exit1_ir : jtag_pkg::shift_ir;
            jtag_pkg::exit1_ir:
                next_state = tms ? jtag_pkg::update_ir : jtag_pkg::pause_ir;
            jtag_pkg::pause_ir:
                next_state = tms ? jtag_pkg::exit2_ir : jtag_pkg::pause_ir;
            jtag_pkg::exit2_ir:
                next_state = tms ? jtag_pkg::update_ir : jtag_pkg::shift_ir;
            jtag_pkg::update_ir:
                next_state = tms ? jtag_pkg::select_dr_scan : jtag_pkg::run_test_idle;
            default:
                next_state = jtag_pkg::test_logic_reset;
        endcase
    end

    // state only moves on a detected tck rising edge
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= jtag_pkg::test_logic_reset;
        else if (tck_rise)
            state <= next_state;
    end

    // controls act in the current state, on the same edge that leaves it
    assign tap_reset  = tck_rise && (state == jtag_pkg::test_logic_reset);
    assign ir_capture = tck_rise && (state == jtag_pkg::capture_ir);
    assign ir_shift   = tck_rise && (state == jtag_pkg::shift_ir);
    assign ir_update  = tck_rise && (state == jtag_pkg::update_ir);
    assign dr_capture = tck_rise && (state == jtag_pkg::capture_dr);
    assign dr_shift   = tck_rise && (state == jtag_pkg::shift_dr);
    assign dr_update  = tck_rise && (state == jtag_pkg::update_dr);

endmodule

/* verilog/tap_data_reg.sv */
`timescale 1ns/1ps

module tap_data_reg
#(
    parameter type      payload_t = logic,
    parameter payload_t INIT      = payload_t'(0),
    parameter bit       WRITABLE  = 1'b0
)
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     tap_reset,
    input  logic     capture_en,
    input  logic     shift_en,
    input  logic     update_en,
    input  logic     tdi,
    output logic     scan_out,
    output payload_t value
);

    localparam int WIDTH = $bits(payload_t);

    logic [WIDTH-1:0] stage;
    payload_t         held;

    // capture the held value, then shift right with tdi entering at the msb
    always_ff @(posedge clk)
    begin
        if (capture_en)
            stage <= held;
        else if (shift_en)
            stage <= (stage >> 1) | (WIDTH'(tdi) << (WIDTH - 1));
    end

    generate
        if (WRITABLE)
        begin : g_writable
            always_ff @(posedge clk)
            begin
                if (!rst_n)
                    held <= INIT;
                else if (tap_reset)
                    held <= INIT;
                else if (update_en)
                    held <= payload_t'(stage);
            end
        end
        else
        begin : g_read_only
            // constant register, capture always sees INIT
            assign held = INIT;
        end
    endgenerate

    // lsb leaves first
    assign scan_out = stage[0];
    assign value    = held;

endmodule

/* verilog/tap_dr_select.sv */
`timescale 1ns/1ps

module tap_dr_select
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tck_fall,
    input  jtag_pkg::tap_state_t state,
    input  jtag_pkg::ir_t        instr,
    input  logic                 dr_capture,
    input  logic                 dr_shift,
    input  logic                 dr_update,
    input  logic                 ir_scan_out,
    input  logic                 idcode_scan_out,
    input  logic                 bypass_scan_out,
    input  logic                 custom_scan_out,
    output logic [2:0]           idcode_en,
    output logic [2:0]           bypass_en,
    output logic [2:0]           custom_en,
    output logic                 jtag_tdo
);

    logic       sel_idcode;
    logic       sel_bypass;
    logic       sel_custom;
    logic [2:0] dr_ctrl;
    logic       dr_tdo;

    // one data path per instruction
    always_comb
    begin
        sel_idcode = 1'b0;
        sel_bypass = 1'b0;
        sel_custom = 1'b0;
        case (instr)
            jtag_pkg::INSTR_IDCODE: sel_idcode = 1'b1;
            jtag_pkg::INSTR_CUSTOM: sel_custom = 1'b1;
            jtag_pkg::INSTR_BYPASS: sel_bypass = 1'b1;
            // unknown codes fall back to bypass
            default:                sel_bypass = 1'b1;
        endcase
    end

    // bit 0 capture, bit 1 shift, bit 2 update
    assign dr_ctrl   = {dr_update, dr_shift, dr_capture};
    assign idcode_en = sel_idcode ? dr_ctrl : 3'b000;
    assign bypass_en = sel_bypass ? dr_ctrl : 3'b000;
    assign custom_en = sel_custom ? dr_ctrl : 3'b000;

    always_comb
    begin
        if (sel_idcode)
            dr_tdo = idcode_scan_out;
        else if (sel_custom)
            dr_tdo = custom_scan_out;
        else
            dr_tdo = bypass_scan_out;
    end

    // tdo changes on the falling edge, held outside the shift states
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            jtag_tdo <= 1'b0;
        else if (tck_fall)
        begin
            if (state == jtag_pkg::shift_ir)
                jtag_tdo <= ir_scan_out;
            else if (state == jtag_pkg::shift_dr)
                jtag_tdo <= dr_tdo;
        end
    end

endmodule

/* verilog/jtag_tap.sv */
`timescale 1ns/1ps

module jtag_tap
(
    input  logic clk,
    input  logic rst_n,
    input  logic jtag_clk,
    input  logic jtag_tms,
    input  logic jtag_tdi,
    output logic jtag_tdo
);

    logic                 tck_rise;
    logic                 tck_fall;
    logic                 tms;
    logic                 tdi;
    jtag_pkg::tap_state_t state;
    logic                 tap_reset;
    logic                 ir_capture;
    logic                 ir_shift;
    logic                 ir_update;
    logic                 dr_capture;
    logic                 dr_shift;
    logic                 dr_update;
    jtag_pkg::ir_t        instr;
    logic [2:0]           idcode_en;
    logic [2:0]           bypass_en;
    logic [2:0]           custom_en;
    logic                 ir_scan_out;
    logic                 idcode_scan_out;
    logic                 bypass_scan_out;
    logic                 custom_scan_out;

    jtag_sync sync_i
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .jtag_clk (jtag_clk),
        .jtag_tms (jtag_tms),
        .jtag_tdi (jtag_tdi),
        .tck_rise (tck_rise),
        .tck_fall (tck_fall),
        .tms      (tms),
        .tdi      (tdi)
    );

    tap_fsm fsm_i
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .tck_rise   (tck_rise),
        .tms        (tms),
        .state      (state),
        .tap_reset  (tap_reset),
        .ir_capture (ir_capture),
        .ir_shift   (ir_shift),
        .ir_update  (ir_update),
        .dr_capture (dr_capture),
        .dr_shift   (dr_shift),
        .dr_update  (dr_update)
    );

    // instruction register, resets to IDCODE
    tap_data_reg #(
        .payload_t (jtag_pkg::ir_t),
        .INIT      (jtag_pkg::INSTR_IDCODE),
        .WRITABLE  (1'b1)
    ) ir_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tap_reset  (tap_reset),
        .capture_en (ir_capture),
        .shift_en   (ir_shift),
        .update_en  (ir_update),
        .tdi        (tdi),
        .scan_out   (ir_scan_out),
        .value      (instr)
    );

    tap_data_reg #(
        .payload_t (jtag_pkg::dr32_t),
        .INIT      (jtag_pkg::IDCODE_VALUE),
        .WRITABLE  (1'b0)
    ) idcode_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tap_reset  (tap_reset),
        .capture_en (idcode_en[0]),
        .shift_en   (idcode_en[1]),
        .update_en  (idcode_en[2]),
        .tdi        (tdi),
        .scan_out   (idcode_scan_out),
        .value      ()
    );

    tap_data_reg #(
        .payload_t (logic),
        .INIT      (1'b0),
        .WRITABLE  (1'b0)
    ) bypass_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tap_reset  (tap_reset),
        .capture_en (bypass_en[0]),
        .shift_en   (bypass_en[1]),
        .update_en  (bypass_en[2]),
        .tdi        (tdi),
        .scan_out   (bypass_scan_out),
        .value      ()
    );

    tap_data_reg #(
        .payload_t (jtag_pkg::dr32_t),
        .INIT      (jtag_pkg::CUSTOM_INIT),
        .WRITABLE  (1'b1)
    ) custom_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tap_reset  (tap_reset),
        .capture_en (custom_en[0]),
        .shift_en   (custom_en[1]),
        .update_en  (custom_en[2]),
        .tdi        (tdi),
        .scan_out   (custom_scan_out),
        .value      ()
    );

    tap_dr_select select_i
    (
        .clk             (clk),
        .rst_n           (rst_n),
        .tck_fall        (tck_fall),
        .state           (state),
        .instr           (instr),
        .dr_capture      (dr_capture),
        .dr_shift        (dr_shift),
        .dr_update       (dr_update),
        .ir_scan_out     (ir_scan_out),
        .idcode_scan_out (idcode_scan_out),
        .bypass_scan_out (bypass_scan_out),
        .custom_scan_out (custom_scan_out),
        .idcode_en       (idcode_en),
        .bypass_en       (bypass_en),
        .custom_en       (custom_en),
        .jtag_tdo        (jtag_tdo)
    );

endmodule

/* sim/jtag_tap_chk.sv */
`timescale 1ns/1ps

module jtag_tap_chk
(
    input logic                 clk,
    input logic                 rst_n,
    input logic                 tck_rise,
    input logic                 tms,
    input logic                 tck_fall,
    input logic                 jtag_tdo,
    input jtag_pkg::tap_state_t state
);

    int unsigned tms_high_run;

    // consecutive tck rises seen with tms high
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            tms_high_run <= 0;
        else if (tck_rise)
            tms_high_run <= tms ? tms_high_run + 1 : 0;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        $changed(state) |-> $past(tck_rise))
    else $error("tap state moved without a tck rising edge");

    assert property (@(posedge clk) disable iff (!rst_n)
        tck_rise && tms && tms_high_run >= jtag_pkg::TLR_TMS_COUNT - 1
        |=> state == jtag_pkg::test_logic_reset)
    else $error("tms held high did not reach test-logic-reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        $changed(jtag_tdo) |-> $past(tck_fall))
    else $error("tdo changed outside the cycle after a tck falling edge");

endmodule

// controller strobes, state and the tdo register all meet at the top level
bind jtag_tap jtag_tap_chk tap_chk_i
(
    .clk      (clk),
    .rst_n    (rst_n),
    .tck_rise (tck_rise),
    .tms      (tms),
    .tck_fall (tck_fall),
    .jtag_tdo (jtag_tdo),
    .state    (state)
);

/* sim/jtag_tap_tb.sv */
`timescale 1ns/1ps

module jtag_tap_tb;

    localparam int PHASE_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 20;
    localparam int BYPASS_BITS   = 16;

    logic            clk;
    logic            rst_n;
    logic            jtag_clk;
    logic            jtag_tms;
    logic            jtag_tdi;
    logic            jtag_tdo;
    int              check_count;
    int              error_count;
    int              timeout_count;
    integer          seed;
    jtag_pkg::dr32_t custom_now;

    jtag_tap dut_i
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .jtag_clk (jtag_clk),
        .jtag_tms (jtag_tms),
        .jtag_tdi (jtag_tdi),
        .jtag_tdo (jtag_tdo)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #5 clk = ~clk;
    end

    function automatic jtag_pkg::dr32_t random_word();
        return $random(seed);
    endfunction

    task automatic check_value(input string test_name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected)
        else
        begin
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
            error_count++;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while ((rst_n !== 1'b1 || jtag_tdo !== 1'b0) && cycles < RESET_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (rst_n !== 1'b1 || jtag_tdo !== 1'b0)
        begin
            $display("reset release with tdo low not seen within %0d cycles", RESET_TIMEOUT);
            timeout_count++;
        end
    endtask

    // low phase with new tms and tdi, tdo sampled just before the rise
    task automatic jtag_cycle(input logic tms_val, input logic tdi_val, output logic tdo_val);
        @(posedge clk);
        jtag_tms <= tms_val;
        jtag_tdi <= tdi_val;
        repeat (PHASE_CYCLES) @(posedge clk);
        tdo_val = jtag_tdo;
        jtag_clk <= 1'b1;
        repeat (PHASE_CYCLES) @(posedge clk);
        jtag_clk <= 1'b0;
    endtask

    task automatic move_tms(input logic tms_val);
        logic unused_tdo;
        jtag_cycle(tms_val, 1'b0, unused_tdo);
    endtask

    task automatic goto_reset();
        repeat (jtag_pkg::TLR_TMS_COUNT)
            move_tms(1'b1);
        move_tms(1'b0);
    endtask

    // lsb first, tms high on the last bit leaves the shift state
    task automatic shift_bits(input int nbits, input logic [63:0] data_in,
                              output logic [63:0] data_out);
        logic tdo_bit;
        data_out = '0;
        for (int i = 0; i < nbits; i++)
        begin
            jtag_cycle(i == nbits - 1, data_in[i], tdo_bit);
            data_out[i] = tdo_bit;
        end
    endtask

    // starts and ends in run-test/idle
    task automatic scan_ir(input jtag_pkg::ir_t data_in, output jtag_pkg::ir_t data_out);
        logic [63:0] bits_out;
        move_tms(1'b1);
        move_tms(1'b1);
        move_tms(1'b0);
        move_tms(1'b0);
        shift_bits(jtag_pkg::IR_WIDTH, 64'(data_in), bits_out);
        move_tms(1'b1);
        move_tms(1'b0);
        data_out = jtag_pkg::ir_t'(bits_out);
    endtask

    // a nonzero pause_at breaks the shift after that many bits
    task automatic scan_dr(input int nbits, input int pause_at, input logic [63:0] data_in,
                           output logic [63:0] data_out);
        logic [63:0] head;
        logic [63:0] tail;
        int          split;
        split = (pause_at > 0) ? pause_at : nbits;
        tail  = '0;
        move_tms(1'b1);
        move_tms(1'b0);
        move_tms(1'b0);
        shift_bits(split, data_in, head);
        if (split < nbits)
        begin
            // exit1-dr into pause-dr, stay a while, then exit2-dr back to shift-dr
            repeat (4)
                move_tms(1'b0);
            move_tms(1'b1);
            move_tms(1'b0);
            shift_bits(nbits - split, data_in >> split, tail);
        end
        move_tms(1'b1);
        move_tms(1'b0);
        data_out = head | (tail << split);
    endtask

    task automatic idcode_after_reset();
        logic [63:0] data_out;
        move_tms(1'b0);
        scan_dr(32, 0, 64'(random_word()), data_out);
        check_value("idcode_after_reset", 64'(jtag_pkg::IDCODE_VALUE), data_out);
    endtask

    task automatic ir_capture_twice();
        jtag_pkg::ir_t ir_out;
        scan_ir(jtag_pkg::INSTR_CUSTOM, ir_out);
        check_value("ir_capture_first", 64'(jtag_pkg::INSTR_IDCODE), 64'(ir_out));
        scan_ir(jtag_pkg::INSTR_CUSTOM, ir_out);
        check_value("ir_capture_second", 64'(jtag_pkg::INSTR_CUSTOM), 64'(ir_out));
    endtask

    task automatic custom_write_read();
        jtag_pkg::dr32_t write_val;
        jtag_pkg::dr32_t next_val;
        logic [63:0]     data_out;
        write_val = random_word();
        next_val  = random_word();
        scan_dr(32, 0, 64'(write_val), data_out);
        check_value("custom_first_read", 64'(jtag_pkg::CUSTOM_INIT), data_out);
        scan_dr(32, 0, 64'(next_val), data_out);
        check_value("custom_read_back", 64'(write_val), data_out);
        custom_now = next_val;
    endtask

    task automatic bypass_scan(input string test_name, input jtag_pkg::ir_t instr);
        jtag_pkg::ir_t ir_out;
        logic [63:0]   mask;
        logic [63:0]   data_in;
        logic [63:0]   data_out;
        mask    = (64'd1 << BYPASS_BITS) - 1;
        data_in = 64'(random_word()) & mask;
        scan_ir(instr, ir_out);
        scan_dr(BYPASS_BITS, 0, data_in, data_out);
        // one bit of delay behind a captured 0
        check_value(test_name, (data_in << 1) & mask, data_out);
    endtask

    task automatic bypass_instructions();
        bypass_scan("bypass_instr", jtag_pkg::INSTR_BYPASS);
        bypass_scan("bypass_unknown", 5'h03);
    endtask

    task automatic reset_by_tms();
        jtag_pkg::ir_t   ir_out;
        jtag_pkg::dr32_t write_val;
        logic [63:0]     data_out;
        write_val = random_word();
        goto_reset();
        scan_dr(32, 0, 64'(random_word()), data_out);
        check_value("tms_reset_idcode", 64'(jtag_pkg::IDCODE_VALUE), data_out);
        scan_ir(jtag_pkg::INSTR_CUSTOM, ir_out);
        check_value("tms_reset_ir", 64'(jtag_pkg::INSTR_IDCODE), 64'(ir_out));
        scan_dr(32, 0, 64'(write_val), data_out);
        check_value("tms_reset_custom", 64'(jtag_pkg::CUSTOM_INIT), data_out);
        custom_now = write_val;
    endtask

    task automatic pause_resume();
        jtag_pkg::dr32_t first_val;
        jtag_pkg::dr32_t second_val;
        logic [63:0]     data_out;
        first_val  = random_word();
        second_val = random_word();
        scan_dr(32, 0, 64'(first_val), data_out);
        check_value("pause_plain_read", 64'(custom_now), data_out);
        scan_dr(32, 13, 64'(second_val), data_out);
        check_value("pause_split_read", 64'(first_val), data_out);
        scan_dr(32, 0, 64'(second_val), data_out);
        check_value("pause_split_write", 64'(second_val), data_out);
    endtask

    initial
    begin
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        seed          = 58;
        custom_now    = jtag_pkg::CUSTOM_INIT;
        rst_n         = 1'b0;
        jtag_clk      = 1'b0;
        jtag_tms      = 1'b0;
        jtag_tdi      = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        wait_reset_release();
        idcode_after_reset();
        ir_capture_twice();
        custom_write_read();
        bypass_instructions();
        reset_by_tms();
        pause_resume();
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* list.f */
verilog/jtag_pkg.sv
verilog/jtag_sync.sv
verilog/tap_fsm.sv
verilog/tap_data_reg.sv
verilog/tap_dr_select.sv
verilog/jtag_tap.sv
sim/jtag_tap_chk.sv
sim/jtag_tap_tb.sv
